//--- source/lenet_mac_pkg.sv
package lenet_mac_pkg;

    // datapath widths.
    localparam int OPERAND_W = 8;
    localparam int PRODUCT_W = 2 * OPERAND_W;
    localparam int ACC_W     = 24;   // 256 terms of the largest product.
    localparam int BIAS_W    = 16;
    localparam int SUM_W     = ACC_W + 2;
    localparam int ACT_W     = 8;

    // requantization.
    localparam int OUT_SHIFT = 8;
    localparam int ACT_MAX   = 255;

    // activation or weight.
    typedef logic [OPERAND_W-1:0] operand_t;

    // approximate multiplier result.
    typedef logic [PRODUCT_W-1:0] product_t;

    // running dot product.
    typedef logic [ACC_W-1:0] acc_t;

    // per-channel bias.
    typedef logic signed [BIAS_W-1:0] bias_t;

    // accumulator plus bias, never overflows.
    typedef logic signed [SUM_W-1:0] sum_t;

    // requantized output activation.
    typedef logic [ACT_W-1:0] act_t;

endpackage

//--- source/mac_stage_if.sv
`timescale 1ns/1ps

interface mac_stage_if;

    logic                      valid;    // product present this cycle.
    logic                      first;    // term opens a dot product.
    logic                      last;     // term closes a dot product.
    lenet_mac_pkg::product_t   product;

    // multiply stage side.
    modport src (
        output valid,
        output first,
        output last,
        output product
    );

    // accumulate stage side, no acknowledge.
    modport dst (
        input valid,
        input first,
        input last,
        input product
    );

endinterface

//--- source/approx_mult_8x8.sv
`timescale 1ns/1ps

module approx_mult_8x8 (
    input  lenet_mac_pkg::operand_t x,
    input  lenet_mac_pkg::operand_t y,
    output lenet_mac_pkg::product_t z
);

    lenet_mac_pkg::operand_t pp [0:7];   // and-gated partial products.
    lenet_mac_pkg::product_t row [0:5];  // compressed middle rows.
    lenet_mac_pkg::product_t upper;      // rows 6 and 7, kept exact.

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    always_comb begin
        row = '{default: '0};

        row[0][2]  = pp[0][1] ^ pp[1][0];
        row[0][3]  = pp[2][1] | pp[3][0];
        row[0][5]  = pp[4][1] | pp[5][0];
        row[0][6]  = pp[2][3] & pp[3][2];
        row[0][7]  = pp[2][5] | pp[3][4];
        row[0][8]  = pp[0][7] | pp[1][6];
        row[0][9]  = pp[2][7] | pp[3][6];
        row[0][10] = pp[2][7] & pp[3][6];
        row[0][11] = pp[4][6] & pp[5][5];
        row[0][12] = pp[5][7];

        row[1][6]  = pp[2][3] | pp[3][2];
        row[1][7]  = pp[4][3] ^ pp[5][2];
        row[1][8]  = pp[1][7];
        row[1][9]  = pp[4][5] ^ pp[5][4];
        row[1][10] = pp[3][7];
        row[1][11] = pp[4][7] & pp[5][6];

        row[2][6]  = pp[2][4] | pp[3][3];
        row[2][8]  = pp[2][6] | pp[3][5];
        row[2][10] = pp[4][5] & pp[5][4];
        row[2][11] = pp[4][7] | pp[5][6];

        row[3][6]  = pp[4][2] | pp[5][1];
        row[3][8]  = pp[4][3] & pp[5][2];
        row[3][10] = pp[4][6] ^ pp[5][5];

        // bit 8 pair split into and/or halves.
        row[4][8]  = pp[4][4] & pp[5][3];
        row[5][8]  = pp[4][4] | pp[5][3];
    end

    assign upper = {1'b0, pp[7], 7'b0} + {2'b00, pp[6], 6'b0};

    assign z = upper + row[0] + row[1] + row[2] + row[3] + row[4] + row[5];

endmodule

//--- source/mult_stage.sv
`timescale 1ns/1ps

module mult_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic                    in_first,
    input  logic                    in_last,
    input  lenet_mac_pkg::operand_t act,
    input  lenet_mac_pkg::operand_t weight,
    input  lenet_mac_pkg::bias_t    bias,
    mac_stage_if.src                out,
    output lenet_mac_pkg::bias_t    out_bias
);

    lenet_mac_pkg::product_t product;

    approx_mult_8x8 approx_mult_8x8_inst (
        .x (act),
        .y (weight),
        .z (product)
    );

    // marks follow the pair by one cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
            out.first <= 1'b0;
            out.last  <= 1'b0;
        end else begin
            out.valid <= in_valid;
            out.first <= in_valid & in_first;
            out.last  <= in_valid & in_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.product <= '0;
            out_bias    <= '0;
        end else begin
            if (in_valid) begin
                out.product <= product;
            end
            // bias rides with the final product.
            if (in_valid && in_last) begin
                out_bias <= bias;
            end
        end
    end

endmodule

//--- source/accum_stage.sv
`timescale 1ns/1ps

module accum_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    mac_stage_if.dst                in,
    input  lenet_mac_pkg::bias_t    in_bias,
    output logic                    sum_valid,
    output lenet_mac_pkg::acc_t     sum,
    output lenet_mac_pkg::bias_t    sum_bias
);

    lenet_mac_pkg::acc_t acc;       // running dot product.
    lenet_mac_pkg::acc_t acc_next;
    lenet_mac_pkg::acc_t term;

    assign term = {8'b0, in.product};

    // load on the first term, add otherwise.
    always_comb begin
        if (in.first) begin
            acc_next = term;
        end else begin
            acc_next = acc + term;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (in.valid) begin
            acc <= acc_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= in.valid & in.last;   // single-cycle pulse.
        end
    end

    // completed sum held until the next vector ends.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum      <= '0;
            sum_bias <= '0;
        end else if (in.valid && in.last) begin
            sum      <= acc_next;
            sum_bias <= in_bias;
        end
    end

endmodule

//--- source/relu_requant_stage.sv
`timescale 1ns/1ps

module relu_requant_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sum_valid,
    input  lenet_mac_pkg::acc_t     sum,
    input  lenet_mac_pkg::bias_t    sum_bias,
    output logic                    out_valid,
    output lenet_mac_pkg::act_t     out_act,
    output lenet_mac_pkg::sum_t     out_sum
);

    lenet_mac_pkg::sum_t biased;
    lenet_mac_pkg::sum_t shifted;
    lenet_mac_pkg::act_t act_sat;

    // zero-extend the sum, sign-extend the bias.
    assign biased  = lenet_mac_pkg::sum_t'({2'b00, sum})
                   + lenet_mac_pkg::sum_t'(sum_bias);
    assign shifted = biased >>> lenet_mac_pkg::OUT_SHIFT;

    always_comb begin
        if (biased < 0) begin
            act_sat = '0;                  // relu.
        end else if (shifted > lenet_mac_pkg::ACT_MAX) begin
            act_sat = lenet_mac_pkg::act_t'(lenet_mac_pkg::ACT_MAX);
        end else begin
            act_sat = lenet_mac_pkg::act_t'(shifted);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_act   <= '0;
            out_sum   <= '0;
        end else begin
            out_valid <= sum_valid;
            if (sum_valid) begin
                out_act <= act_sat;
                out_sum <= biased;
            end
        end
    end

endmodule

//--- source/lenet_mac_top.sv
`timescale 1ns/1ps

module lenet_mac_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic                    in_first,
    input  logic                    in_last,
    input  lenet_mac_pkg::operand_t act,
    input  lenet_mac_pkg::operand_t weight,
    input  lenet_mac_pkg::bias_t    bias,
    output logic                    out_valid,
    output lenet_mac_pkg::act_t     out_act,
    output lenet_mac_pkg::sum_t     out_sum
);

    mac_stage_if mac_if ();

    lenet_mac_pkg::bias_t mult_bias;    // bias aligned to the last product.
    logic                 sum_valid;
    lenet_mac_pkg::acc_t  sum;
    lenet_mac_pkg::bias_t sum_bias;

    mult_stage mult_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_first (in_first),
        .in_last  (in_last),
        .act      (act),
        .weight   (weight),
        .bias     (bias),
        .out      (mac_if),
        .out_bias (mult_bias)
    );

    accum_stage accum_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (mac_if),
        .in_bias   (mult_bias),
        .sum_valid (sum_valid),
        .sum       (sum),
        .sum_bias  (sum_bias)
    );

    relu_requant_stage relu_requant_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum_valid (sum_valid),
        .sum       (sum),
        .sum_bias  (sum_bias),
        .out_valid (out_valid),
        .out_act   (out_act),
        .out_sum   (out_sum)
    );

endmodule

//--- tests/lenet_mac_tb.sv
`timescale 1ns/1ps

module lenet_mac_tb;

    localparam int RESET_CYCLES = 5;
    localparam int LATENCY      = 3;            // last term to out_valid.
    localparam int DRAIN_CYCLES = LATENCY + 1;
    localparam int SLACK_CYCLES = 20;

    typedef struct packed {
        logic                    valid;
        logic                    first;
        logic                    last;
        lenet_mac_pkg::operand_t act;
        lenet_mac_pkg::operand_t weight;
        lenet_mac_pkg::bias_t    bias;
        lenet_mac_pkg::act_t     exp_act;
        lenet_mac_pkg::sum_t     exp_sum;
    } case_row_t;

    typedef struct packed {
        int                  cycle;             // negedge where out_valid is due.
        lenet_mac_pkg::act_t act;
        lenet_mac_pkg::sum_t sum;
    } result_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    in_valid;
    logic                    in_first;
    logic                    in_last;
    lenet_mac_pkg::operand_t act;
    lenet_mac_pkg::operand_t weight;
    lenet_mac_pkg::bias_t    bias;
    logic                    out_valid;
    lenet_mac_pkg::act_t     out_act;
    lenet_mac_pkg::sum_t     out_sum;

    case_row_t rows [$];
    result_t   pending [$];
    int        cycle = 0;
    int        cycle_limit = 0;
    int        seed = 82853;

    lenet_mac_top lenet_mac_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_first  (in_first),
        .in_last   (in_last),
        .act       (act),
        .weight    (weight),
        .bias      (bias),
        .out_valid (out_valid),
        .out_act   (out_act),
        .out_sum   (out_sum)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at %0d ns", $time);
    endtask

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual != expected) begin
            abort_run($sformatf("error at %0d ns: %s is %0d, expected %0d",
                                $time, name, actual, expected));
        end
    endtask

    task automatic load_cases();
        int        fd;
        int        count;
        string     line;
        int        f_valid, f_first, f_last;
        int        f_act, f_weight, f_bias;
        int        f_exp_act, f_exp_sum;
        case_row_t row;
        fd = $fopen("tests/mac_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the cases file tests/mac_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            count = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;                       // blank or comment.
            end
            count = $sscanf(line, "%d %d %d %d %d %d %d %d", f_valid, f_first, f_last,
                            f_act, f_weight, f_bias, f_exp_act, f_exp_sum);
            if (count != 8) begin
                abort_run($sformatf("cases file line has %0d fields instead of 8: %s",
                                    count, line));
            end
            row.valid   = f_valid[0];
            row.first   = f_first[0];
            row.last    = f_last[0];
            row.act     = f_act[7:0];
            row.weight  = f_weight[7:0];
            row.bias    = f_bias[15:0];
            row.exp_act = f_exp_act[7:0];
            row.exp_sum = f_exp_sum[25:0];
            rows.push_back(row);
        end
        $fclose(fd);
    endtask

    task automatic drive_row(input case_row_t row);
        result_t res;
        in_valid = row.valid;
        if (row.valid) begin
            in_first = row.first;
            in_last  = row.last;
            act      = row.act;
            weight   = row.weight;
            bias     = row.bias;
        end else begin
            // idle cycle, everything but in_valid carries noise.
            in_first = $random(seed);
            in_last  = $random(seed);
            act      = $random(seed);
            weight   = $random(seed);
            bias     = $random(seed);
        end
        if (row.valid && row.last) begin
            res.cycle = cycle + LATENCY;
            res.act   = row.exp_act;
            res.sum   = row.exp_sum;
            pending.push_back(res);
        end
    endtask

    // cycle count and watchdog.
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            abort_run($sformatf("timeout, run still going after %0d cycles", cycle));
        end
    end

    always @(negedge clk) begin : monitor
        result_t res;
        if (!rst_n) begin
            check_value("out_valid", longint'(out_valid !== 1'b0), 0);
        end else if (out_valid !== 1'b0) begin
            if (pending.size() == 0) begin
                abort_run("out_valid went high with no result pending");
            end else begin
                res = pending.pop_front();
                check_value("out_valid cycle", cycle, res.cycle);
                check_value("out_act", out_act, res.act);
                check_value("out_sum", out_sum, res.sum);
            end
        end
    end

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_first = 1'b0;
        in_last  = 1'b0;
        act      = '0;
        weight   = '0;
        bias     = '0;
        load_cases();
        cycle_limit = RESET_CYCLES + rows.size() + SLACK_CYCLES;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        foreach (rows[i]) begin
            drive_row(rows[i]);
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_first = 1'b0;
        in_last  = 1'b0;
        repeat (DRAIN_CYCLES) @(negedge clk);
        if (pending.size() != 0) begin
            abort_run($sformatf("%0d results never showed up on out_valid", pending.size()));
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- tests/mac_cases.txt
# valid first last act weight bias exp_act exp_sum, all decimal
# expected columns only matter on rows with valid and last high
# zero operands
1 1 1 0 200 77 0 77
1 1 1 123 0 1000 3 1000
1 1 1 0 0 -5 0 -5
# approximate products, one-term vectors
1 1 1 192 200 0 150 38400
1 1 1 64 255 0 63 16320
1 1 1 128 3 0 1 384
1 1 1 1 1 10 0 10
1 1 1 1 2 0 0 4
1 1 1 4 255 0 4 1032
1 1 1 16 255 0 15 4064
1 1 1 32 255 0 31 8160
1 1 1 255 255 0 252 64744
1 1 1 65 128 -48 32 8400
# multi-term with idle cycles inside
1 1 0 192 200 0 0 0
0 1 1 255 255 0 0 0
1 0 0 128 3 0 0 0
0 0 0 0 0 0 0 0
1 0 1 32 255 100 183 47044
# relu and saturation
1 1 1 4 255 -2000 0 -968
1 1 0 255 255 0 0 0
1 0 0 255 255 0 0 0
1 0 1 255 255 0 255 194232
1 1 1 255 255 32767 255 97511
# mixed vectors back to back
1 1 0 68 85 0 0 0
1 0 0 48 15 0 0 0
1 0 1 8 240 -300 31 7988
1 1 0 2 128 0 0 0
1 0 1 192 200 5 151 38661
1 1 1 48 15 -608 0 0
1 1 0 16 255 0 0 0
1 0 0 0 9 0 0 0
0 0 0 77 77 0 0 0
1 0 0 64 255 0 0 0
1 0 1 68 85 1234 106 27378
1 1 1 8 240 -32768 0 -30848

//--- flist.f
source/lenet_mac_pkg.sv
source/mac_stage_if.sv
source/approx_mult_8x8.sv
source/mult_stage.sv
source/accum_stage.sv
source/relu_requant_stage.sv
source/lenet_mac_top.sv
tests/lenet_mac_tb.sv

//--- Bender.yml
package:
  name: lenet_mac

sources:
  - source/lenet_mac_pkg.sv
  - source/mac_stage_if.sv
  - source/approx_mult_8x8.sv
  - source/mult_stage.sv
  - source/accum_stage.sv
  - source/relu_requant_stage.sv
  - source/lenet_mac_top.sv
  - target: test
    files:
      - tests/lenet_mac_tb.sv
